// ==== Makefile ====
# Verilator build and run for the SoC event path testbench
# Every variable below can be overridden on the make command line

VERILATOR ?= verilator
TOP       ?= tb_soc_event_path
FILELIST  ?= soc_event_path.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: help build test clean

help:
	@echo "Targets:"
	@echo "  help   show this list"
	@echo "  build  compile $(TOP) from $(FILELIST) into $(BUILD_DIR)"
	@echo "  test   build, run and search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

test: build
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== hdl/event_capture.sv ====
// Event capture: one pending flag per source, drained by fixed priority
// Inputs are single-cycle pulses synchronous to clk_i, except ref_clk_i
// ref_clk_i is a slow level; its edges show up a few cycles late
// A pulse on a flag that is still pending is dropped and flagged on err_event_o
// push_o and push_word_o are registered, the FIFO writes one cycle later
module event_capture
    import soc_event_pkg::*;
(
    input  logic                    clk_i,
    input  logic                    reset_i,
    input  logic                    ref_clk_i,
    input  logic                    full_i,
    input  logic [N_PER_EVENTS-1:0] per_events_i,
    input  logic [N_CL_EVENTS-1:0]  cl_events_i,
    output logic                    push_o,
    output logic                    err_event_o,
    output event_word_u             push_word_o
);

    logic [1:0]           ref_sync_q;
    logic                 ref_prev_q;
    logic                 ref_rise;
    logic                 ref_fall;

    logic [N_SOURCES-1:0] src_pulse;
    logic [N_SOURCES-1:0] pending_q;
    logic [N_SOURCES-1:0] pending_next;
    logic [N_SOURCES-1:0] pick_onehot;
    logic [N_SOURCES-1:0] clear_vec;
    logic                 pick_found;
    logic                 take;
    logic                 lost;
    event_word_u          pick_word;

    // Map a flag number onto its class and index
    function automatic event_word_u encode_source(input int src);
        event_word_u word;
        if (src < N_REF_EVENTS) begin
            word.fields.cls = CLASS_REF;
            word.fields.idx = EVNT_INDEX_W'(src);
        end else if (src < N_REF_EVENTS + N_PER_EVENTS) begin
            word.fields.cls = CLASS_PERIPH;
            word.fields.idx = EVNT_INDEX_W'(src - N_REF_EVENTS);
        end else begin
            word.fields.cls = CLASS_CLUSTER;
            word.fields.idx = EVNT_INDEX_W'(src - N_REF_EVENTS - N_PER_EVENTS);
        end
        return word;
    endfunction

    //////////////////////////////////////////////////
    // Reference clock edges
    //////////////////////////////////////////////////
    assign ref_rise = ref_sync_q[1] & ~ref_prev_q;
    assign ref_fall = ~ref_sync_q[1] & ref_prev_q;

    // Flag 0 is the rising edge, flag 1 the falling edge
    assign src_pulse = {cl_events_i, per_events_i, ref_fall, ref_rise};

    //////////////////////////////////////////////////
    // Priority pick and flag update
    //////////////////////////////////////////////////
    always_comb begin
        pick_found  = 1'b0;
        pick_onehot = '0;
        pick_word   = '0;
        // Scan downwards so the lowest set flag wins
        for (int i = N_SOURCES - 1; i >= 0; i--) begin
            if (pending_q[i]) begin
                pick_found     = 1'b1;
                pick_onehot    = '0;
                pick_onehot[i] = 1'b1;
                pick_word      = encode_source(i);
            end
        end
    end

    assign take      = pick_found & ~full_i;
    assign clear_vec = take ? pick_onehot : '0;

    // A flag leaving this cycle may be set again without loss
    assign lost         = |(src_pulse & pending_q & ~clear_vec);
    assign pending_next = (pending_q & ~clear_vec) | src_pulse;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ref_sync_q  <= '0;
            ref_prev_q  <= 1'b0;
            pending_q   <= '0;
            push_o      <= 1'b0;
            err_event_o <= 1'b0;
        end else begin
            ref_sync_q  <= {ref_sync_q[0], ref_clk_i};
            ref_prev_q  <= ref_sync_q[1];
            pending_q   <= pending_next;
            push_o      <= take;
            err_event_o <= lost;
        end
    end

    // Word register, only meaningful while push_o is high
    always_ff @(posedge clk_i) begin
        if (take) begin
            push_word_o <= pick_word;
        end
    end

endmodule

// ==== hdl/event_dispatch.sv ====
// Event dispatch: routes the FIFO head to the FC or the cluster port
// CLUSTER class goes to the cluster port, every other class to the FC port
// One output register per port; data holds while valid is high and ready low
// In-order single head: a blocked port also stalls words for the other one
module event_dispatch
    import soc_event_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic                  empty_i,
    input  logic                  fc_event_ready_i,
    input  logic                  cl_event_ready_i,
    input  event_word_u           head_word_i,
    output logic                  pop_o,
    output logic                  fc_event_valid_o,
    output logic                  cl_event_valid_o,
    output logic [EVNT_WIDTH-1:0] fc_event_data_o,
    output logic [EVNT_WIDTH-1:0] cl_event_data_o
);

    // Port vectors: bit 0 is the FC port, bit 1 the cluster port
    logic [1:0]                 port_ready;
    logic [1:0]                 port_free;
    logic [1:0]                 load;
    logic [1:0]                 valid_q;
    logic [1:0][EVNT_WIDTH-1:0] data_q;
    logic                       sel_cl;

    //////////////////////////////////////////////////
    // Class decode and pop
    //////////////////////////////////////////////////
    assign sel_cl = (head_word_i.fields.cls == CLASS_CLUSTER);

    assign port_ready = {cl_event_ready_i, fc_event_ready_i};

    // A register can take a word when empty or handing off this cycle
    assign port_free = ~valid_q | port_ready;

    assign pop_o = ~empty_i & (sel_cl ? port_free[1] : port_free[0]);

    assign load[0] = pop_o & ~sel_cl;
    assign load[1] = pop_o & sel_cl;

    //////////////////////////////////////////////////
    // Output registers
    //////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q <= '0;
        end else begin
            for (int p = 0; p < 2; p++) begin
                if (load[p]) begin
                    valid_q[p] <= 1'b1;
                end else if (port_ready[p]) begin
                    valid_q[p] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        for (int p = 0; p < 2; p++) begin
            if (load[p]) begin
                data_q[p] <= head_word_i.raw;
            end
        end
    end

    assign fc_event_valid_o = valid_q[0];
    assign fc_event_data_o  = data_q[0];
    assign cl_event_valid_o = valid_q[1];
    assign cl_event_data_o  = data_q[1];

endmodule

// ==== hdl/event_fifo.sv ====
// Synchronous FIFO of event words, FIFO_DEPTH entries
// The writer must hold off while full_o is high; no overflow check here
// full_o also counts a word already on push_i, since the writer is registered
// Head is read combinationally, a word written at an edge is visible after it
module event_fifo
    import soc_event_pkg::*;
(
    input  logic        clk_i,
    input  logic        reset_i,
    input  logic        push_i,
    input  logic        pop_i,
    input  event_word_u push_word_i,
    output logic        full_o,
    output logic        empty_o,
    output event_word_u head_word_o
);

    event_word_u           mem_q [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr_q;
    logic [FIFO_PTR_W-1:0] rd_ptr_q;
    logic [FIFO_CNT_W-1:0] count_q;

    //////////////////////////////////////////////////
    // Status
    //////////////////////////////////////////////////
    assign empty_o = (count_q == '0);

    // Full one entry early when a write is already in flight
    assign full_o = (count_q == FIFO_CNT_W'(FIFO_DEPTH)) ||
                    ((count_q == FIFO_CNT_W'(FIFO_DEPTH - 1)) && push_i);

    assign head_word_o = mem_q[rd_ptr_q];

    //////////////////////////////////////////////////
    // Pointers and occupancy
    //////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push_i, pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Storage
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= push_word_i;
        end
    end

endmodule

// ==== hdl/soc_event_path.sv ====
// SoC event path: capture, FIFO and dispatch of peripheral events
// Every event is delivered, there are no masks
// Peripheral and cluster inputs are single-cycle pulses on clk_i
// Empty path with ready high: valid rises 3 cycles after the sampling edge
module soc_event_path
    import soc_event_pkg::*;
(
    input  logic                    clk_i,
    input  logic                    reset_i,
    input  logic                    ref_clk_i,
    input  logic [N_PER_EVENTS-1:0] per_events_i,
    input  logic [N_CL_EVENTS-1:0]  cl_events_i,

    input  logic                    fc_event_ready_i,
    output logic                    fc_event_valid_o,
    output logic [EVNT_WIDTH-1:0]   fc_event_data_o,

    input  logic                    cl_event_ready_i,
    output logic                    cl_event_valid_o,
    output logic [EVNT_WIDTH-1:0]   cl_event_data_o,

    output logic                    err_event_o
);

    logic        s_push;
    logic        s_pop;
    logic        s_full;
    logic        s_empty;
    event_word_u s_push_word;
    event_word_u s_head_word;

    //////////////////////////////////////////////////
    // Producer
    //////////////////////////////////////////////////
    event_capture u_capture (
        .clk_i        ( clk_i        ),
        .reset_i      ( reset_i      ),
        .ref_clk_i    ( ref_clk_i    ),
        .full_i       ( s_full       ),
        .per_events_i ( per_events_i ),
        .cl_events_i  ( cl_events_i  ),
        .push_o       ( s_push       ),
        .err_event_o  ( err_event_o  ),
        .push_word_o  ( s_push_word  )
    );

    // Buffer
    event_fifo u_fifo (
        .clk_i       ( clk_i       ),
        .reset_i     ( reset_i     ),
        .push_i      ( s_push      ),
        .pop_i       ( s_pop       ),
        .push_word_i ( s_push_word ),
        .full_o      ( s_full      ),
        .empty_o     ( s_empty     ),
        .head_word_o ( s_head_word )
    );

    //////////////////////////////////////////////////
    // Consumer
    //////////////////////////////////////////////////
    event_dispatch u_dispatch (
        .clk_i            ( clk_i            ),
        .reset_i          ( reset_i          ),
        .empty_i          ( s_empty          ),
        .fc_event_ready_i ( fc_event_ready_i ),
        .cl_event_ready_i ( cl_event_ready_i ),
        .head_word_i      ( s_head_word      ),
        .pop_o            ( s_pop            ),
        .fc_event_valid_o ( fc_event_valid_o ),
        .cl_event_valid_o ( cl_event_valid_o ),
        .fc_event_data_o  ( fc_event_data_o  ),
        .cl_event_data_o  ( cl_event_data_o  )
    );

endmodule

// ==== hdl/soc_event_pkg.sv ====
// Shared constants and the event word for the SoC event path
// An event word is a 3-bit class over a 5-bit source index
// FIFO_DEPTH must stay a power of two because the pointers wrap freely
package soc_event_pkg;

    //////////////////////////////////////////////////
    // Event word geometry
    //////////////////////////////////////////////////
    localparam int EVNT_WIDTH   = 8;
    localparam int EVNT_CLASS_W = 3;
    localparam int EVNT_INDEX_W = 5;

    // Sources in priority order: ref clock edges, peripheral, cluster
    localparam int N_REF_EVENTS = 2;
    localparam int N_PER_EVENTS = 16;
    localparam int N_CL_EVENTS  = 4;
    localparam int N_SOURCES    = N_REF_EVENTS + N_PER_EVENTS + N_CL_EVENTS;

    //////////////////////////////////////////////////
    // Event FIFO
    //////////////////////////////////////////////////
    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_PTR_W = 3;
    localparam int FIFO_CNT_W = FIFO_PTR_W + 1;

    // Class codes
    localparam logic [EVNT_CLASS_W-1:0] CLASS_PERIPH  = 3'd0;
    localparam logic [EVNT_CLASS_W-1:0] CLASS_REF     = 3'd1;
    localparam logic [EVNT_CLASS_W-1:0] CLASS_CLUSTER = 3'd2;

    // Raw view for storage and ports, field view for encode and decode
    typedef union packed {
        logic [EVNT_WIDTH-1:0] raw;
        struct packed {
            logic [EVNT_CLASS_W-1:0] cls;
            logic [EVNT_INDEX_W-1:0] idx;
        } fields;
    } event_word_u;

endpackage

// ==== sim/tb_vectors.svh ====
// Stimulus table for the SoC event path testbench, included inside its top module
// Stalled rows pulse a single line; the model then expects 10 held words per row
// Rows that pulse several lines need a spacing above the number of lines pulsed
// ref_clk_i toggles follow the pulses of a row, so mixing both is left out
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

localparam int N_ROWS = 10;

// Columns: peripheral lines, cluster lines, repeats, spacing in cycles,
// ready mode, ref_clk_i toggles, expected err_event_o pulses
localparam row_t ROWS [N_ROWS] = '{
    '{16'h0007, 4'h0,  1,  8, RDY_ALWAYS, 0, 0},
    '{16'h8421, 4'h0,  3, 10, RDY_ALWAYS, 0, 0},
    '{16'h0000, 4'hF,  2,  8, RDY_ALWAYS, 0, 0},
    '{16'h0A05, 4'h5,  2, 10, RDY_ALWAYS, 0, 0},
    '{16'h0000, 4'h0,  0,  6, RDY_ALWAYS, 6, 0},
    '{16'h00F0, 4'h3,  6, 40, RDY_RANDOM, 0, 0},
    '{16'h0000, 4'h0,  0,  8, RDY_RANDOM, 8, 0},
    '{16'h0020, 4'h0, 13,  4, RDY_STALL,  0, 3},
    '{16'h0000, 4'h2, 13,  4, RDY_STALL,  0, 3},
    '{16'h1111, 4'h8,  4, 30, RDY_RANDOM, 0, 0}
};

`endif

// ==== sim/tb_soc_event_path.sv ====
// Testbench for soc_event_path that applies the table in tb_vectors.svh row by row
// Expected words follow the priority and class rules, one queue per port
// Outputs are sampled on the falling edge, inputs change 1 unit after the rising edge
// Runs stop at the first mismatch; a cycle limit from the table bounds the run
module tb_soc_event_path
    import soc_event_pkg::*;
();

    localparam logic [1:0] RDY_ALWAYS = 2'd0;
    localparam logic [1:0] RDY_STALL  = 2'd1;
    localparam logic [1:0] RDY_RANDOM = 2'd2;

    // Output register, FIFO and one pending flag
    localparam int STALL_DEPTH = 10;
    localparam int IDLE_GAP    = 10;
    localparam int DRAIN_SLACK = 300;

    typedef struct packed {
        logic [N_PER_EVENTS-1:0] per;
        logic [N_CL_EVENTS-1:0]  cl;
        int                      reps;
        int                      spacing;
        logic [1:0]              mode;
        int                      toggles;
        int                      exp_err;
    } row_t;

`include "tb_vectors.svh"

    logic                    clk_i = 1'b0;
    logic                    reset_i;
    logic                    ref_clk_i;
    logic [N_PER_EVENTS-1:0] per_events_i;
    logic [N_CL_EVENTS-1:0]  cl_events_i;
    logic                    fc_event_ready_i;
    logic                    fc_event_valid_o;
    logic [EVNT_WIDTH-1:0]   fc_event_data_o;
    logic                    cl_event_ready_i;
    logic                    cl_event_valid_o;
    logic [EVNT_WIDTH-1:0]   cl_event_data_o;
    logic                    err_event_o;

    event_word_u exp_fc_q [$];
    event_word_u exp_cl_q [$];
    logic [1:0]  ready_mode;
    logic [1:0]  hold_q = '0;
    event_word_u held_word [2];
    int          err_seen = 0;
    int          cycle_cnt = 0;
    int          cycle_limit;

    soc_event_path u_dut (.*);

    initial begin
        forever #5 clk_i = ~clk_i;
    end

    //////////////////////////////////////////////////
    // Failure reporting and compares
    //////////////////////////////////////////////////
    task automatic stop_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic value_error(input string msg);
        stop_run($sformatf("** Error at time %0t: %s", $time, msg));
    endtask

    task automatic check_event(input string port, input event_word_u got, input event_word_u want);
        if (got.raw !== want.raw) begin
            value_error($sformatf("%s port got class %0d index %0d, expected class %0d index %0d",
                port, got.fields.cls, got.fields.idx, want.fields.cls, want.fields.idx));
        end
    endtask

    task automatic check_count(input string what, input int got, input int want);
        if (got != want) begin
            value_error($sformatf("%s: got %0d, expected %0d", what, got, want));
        end
    endtask

    function automatic event_word_u make_word(input logic [2:0] cls, input int idx);
        event_word_u word;
        word.fields.cls = cls;
        word.fields.idx = 5'(idx);
        return word;
    endfunction

    //////////////////////////////////////////////////
    // Output monitor
    //////////////////////////////////////////////////
    task automatic observe_port(input int p, input logic valid, input logic ready,
                                input event_word_u data);
        event_word_u want;
        string       name;
        int          left;
        name = (p == 0) ? "FC" : "cluster";
        left = (p == 0) ? exp_fc_q.size() : exp_cl_q.size();
        // A waiting word keeps valid and data until ready
        if (hold_q[p]) begin
            if (!valid) begin
                stop_run($sformatf("%s port dropped valid before ready at time %0t", name, $time));
            end
            check_event(name, data, held_word[p]);
        end
        if (valid && ready) begin
            if (left == 0) begin
                stop_run($sformatf("%s port sent a word that no event explains at time %0t",
                    name, $time));
            end
            if (p == 0) begin
                want = exp_fc_q.pop_front();
            end else begin
                want = exp_cl_q.pop_front();
            end
            check_event(name, data, want);
        end
        hold_q[p]    = valid & ~ready;
        held_word[p] = data;
    endtask

    always @(negedge clk_i) begin
        if (reset_i === 1'b0) begin
            observe_port(0, fc_event_valid_o, fc_event_ready_i, fc_event_data_o);
            observe_port(1, cl_event_valid_o, cl_event_ready_i, cl_event_data_o);
            if (err_event_o) begin
                err_seen++;
            end
        end
    end

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) begin
            stop_run($sformatf("Timeout: the run did not finish within %0d cycles", cycle_limit));
        end
    end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////
    function automatic int compute_limit();
        int total;
        total = 20 + IDLE_GAP;
        for (int r = 0; r < N_ROWS; r++) begin
            total += (ROWS[r].reps + ROWS[r].toggles) * ROWS[r].spacing;
            total += IDLE_GAP + DRAIN_SLACK;
        end
        return total;
    endfunction

    // One clock, then clear pulses and drive ready for the mode
    task automatic step();
        @(posedge clk_i);
        #1;
        per_events_i = '0;
        cl_events_i  = '0;
        case (ready_mode)
            RDY_ALWAYS: begin
                fc_event_ready_i = 1'b1;
                cl_event_ready_i = 1'b1;
            end
            RDY_STALL: begin
                fc_event_ready_i = 1'b0;
                cl_event_ready_i = 1'b0;
            end
            default: begin
                fc_event_ready_i = 1'($urandom);
                cl_event_ready_i = 1'($urandom);
            end
        endcase
    endtask

    // Lowest line first within each port; stalled rows hold only STALL_DEPTH words
    task automatic expect_pulses(input row_t row, inout int held);
        for (int n = 0; n < N_PER_EVENTS; n++) begin
            if (row.per[n] && (row.mode != RDY_STALL || held < STALL_DEPTH)) begin
                exp_fc_q.push_back(make_word(CLASS_PERIPH, n));
                held++;
            end
        end
        for (int n = 0; n < N_CL_EVENTS; n++) begin
            if (row.cl[n] && (row.mode != RDY_STALL || held < STALL_DEPTH)) begin
                exp_cl_q.push_back(make_word(CLASS_CLUSTER, n));
                held++;
            end
        end
    endtask

    task automatic run_row(input int r);
        row_t row;
        int   held;
        int   err_base;
        row        = ROWS[r];
        held       = 0;
        err_base   = err_seen;
        ready_mode = row.mode;
        for (int k = 0; k < row.reps; k++) begin
            step();
            per_events_i = row.per;
            cl_events_i  = row.cl;
            expect_pulses(row, held);
            repeat (row.spacing - 1) step();
        end
        // Rising edge gives index 0, falling edge index 1
        for (int k = 0; k < row.toggles; k++) begin
            step();
            ref_clk_i = ~ref_clk_i;
            exp_fc_q.push_back(make_word(CLASS_REF, ref_clk_i ? 0 : 1));
            repeat (row.spacing - 1) step();
        end
        if (row.mode == RDY_STALL) begin
            ready_mode = RDY_ALWAYS;
        end
        while (exp_fc_q.size() != 0 || exp_cl_q.size() != 0) begin
            step();
        end
        repeat (IDLE_GAP) step();
        check_count($sformatf("err_event_o pulses in row %0d", r),
                    err_seen - err_base, row.exp_err);
    endtask

    initial begin
        void'($urandom(32'h589d0004));
        cycle_limit      = compute_limit();
        reset_i          = 1'b1;
        ref_clk_i        = 1'b0;
        per_events_i     = '0;
        cl_events_i      = '0;
        fc_event_ready_i = 1'b0;
        cl_event_ready_i = 1'b0;
        ready_mode       = RDY_ALWAYS;
        repeat (10) @(posedge clk_i);
        #1;
        reset_i = 1'b0;
        // Quiet outputs until the first pulse
        repeat (IDLE_GAP) begin
            @(negedge clk_i);
            if (fc_event_valid_o !== 1'b0 || cl_event_valid_o !== 1'b0 ||
                err_event_o !== 1'b0) begin
                stop_run("An output went high after reset with no input applied");
            end
        end
        for (int r = 0; r < N_ROWS; r++) begin
            run_row(r);
        end
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// ==== soc_event_path.f ====
+incdir+sim
hdl/soc_event_pkg.sv
hdl/event_capture.sv
hdl/event_fifo.sv
hdl/event_dispatch.sv
hdl/soc_event_path.sv
sim/tb_soc_event_path.sv
